//--- Bender.yml
package:
  name: core_spine

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/core_pkg.sv
      - hdl/inst_decode_exec.sv
      - hdl/operand_bypass.sv
      - hdl/pipe_slot.sv
      - hdl/reg_file.sv
      - hdl/core_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_clock_gen.sv
      - sim/core_tb.sv

//--- hdl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and address width
`define XLEN 32

// general register count, r0 included
`define REG_NUM 32

// slots between execute and register write, any value >= 1
`define N_SLOTS 3

// opcode fields, compared against inst[31:15], inst[31:22], inst[31:25]
`define OP_ADD_W   17'h00020
`define OP_ADDI_W  10'h00a
`define OP_LU12I_W 7'h0a

// debug write enable, one bit per byte lane
`define DBG_WEN_W 4

`endif

//--- hdl/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    // one architectural data word
    typedef logic [`XLEN-1:0] data_t;

    // general register index
    typedef logic [$clog2(`REG_NUM)-1:0] reg_idx_t;

    // one retired instruction as it travels to writeback
    // msb first, 102 bits in total
    typedef struct packed {
        // fetch address of the instruction
        data_t    pc;
        // raw instruction word, kept for the debug port
        data_t    inst;
        // register write request
        // only for a known opcode with rd other than r0
        logic     wen;
        // destination register
        reg_idx_t wnum;
        // value for the destination
        data_t    result;
    } commit_t;

endpackage

//--- hdl/core_top.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_top import core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  logic [`XLEN-1:0]      inst,
    input  logic [`XLEN-1:0]      inst_pc,
    output logic                  debug_wb_valid,
    output logic [`XLEN-1:0]      debug_wb_pc,
    output logic [`XLEN-1:0]      debug_wb_inst,
    output logic [`DBG_WEN_W-1:0] debug_wb_rf_wen,
    output reg_idx_t              debug_wb_rf_wnum,
    output logic [`XLEN-1:0]      debug_wb_rf_wdata
);

    // decode read indices, shared by bypass, slots and register file
    reg_idx_t                       rj_idx;
    reg_idx_t                       rk_idx;

    // operands after bypass, and raw register file data
    logic [`XLEN-1:0]               src1;
    logic [`XLEN-1:0]               src2;
    logic [`XLEN-1:0]               rf_data1;
    logic [`XLEN-1:0]               rf_data2;

    // slot chain, entry 0 is the decode output
    // entry i+1 is the output of slot i
    logic [`N_SLOTS:0]              chain_valid;
    commit_t                        chain_commit [`N_SLOTS+1];

    // forwarding taps, one per slot
    logic [`N_SLOTS-1:0]            slot_hit1;
    logic [`N_SLOTS-1:0]            slot_hit2;
    logic [`N_SLOTS-1:0][`XLEN-1:0] slot_result;

    inst_decode_exec i_inst_decode_exec (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .src1       (src1),
        .src2       (src2),
        .rj_idx     (rj_idx),
        .rk_idx     (rk_idx),
        .out_valid  (chain_valid[0]),
        .out_commit (chain_commit[0])
    );

    // memory and writeback stand-ins
    for (genvar i = 0; i < `N_SLOTS; i++) begin : g_slot
        pipe_slot i_pipe_slot (
            .clk        (clk),
            .arst_n     (arst_n),
            .in_valid   (chain_valid[i]),
            .in_commit  (chain_commit[i]),
            .rd_idx1    (rj_idx),
            .rd_idx2    (rk_idx),
            .out_valid  (chain_valid[i+1]),
            .out_commit (chain_commit[i+1]),
            .hit1       (slot_hit1[i]),
            .hit2       (slot_hit2[i])
        );
        assign slot_result[i] = chain_commit[i+1].result;
    end

    operand_bypass i_operand_bypass (
        .rj_idx      (rj_idx),
        .rk_idx      (rk_idx),
        .rf_data1    (rf_data1),
        .rf_data2    (rf_data2),
        .slot_hit1   (slot_hit1),
        .slot_hit2   (slot_hit2),
        .slot_result (slot_result),
        .src1        (src1),
        .src2        (src2)
    );

    // last slot retires into the register file
    reg_file i_reg_file (
        .clk               (clk),
        .arst_n            (arst_n),
        .rd_idx1           (rj_idx),
        .rd_idx2           (rk_idx),
        .commit_valid      (chain_valid[`N_SLOTS]),
        .commit            (chain_commit[`N_SLOTS]),
        .rdata1            (rf_data1),
        .rdata2            (rf_data2),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_inst     (debug_wb_inst),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

//--- hdl/inst_decode_exec.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module inst_decode_exec import core_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             inst_valid,
    input  logic [`XLEN-1:0] inst,
    input  logic [`XLEN-1:0] inst_pc,
    input  logic [`XLEN-1:0] src1,
    input  logic [`XLEN-1:0] src2,
    output reg_idx_t         rj_idx,
    output reg_idx_t         rk_idx,
    output logic             out_valid,
    output commit_t          out_commit
);

    // decode latch
    logic        lat_valid;
    data_t       lat_inst;
    data_t       lat_pc;

    // decoded fields
    reg_idx_t    rd_idx;
    logic [11:0] si12;
    logic [19:0] si20;

    // opcode matches
    logic        is_add_w;
    logic        is_addi_w;
    logic        is_lu12i_w;
    logic        known_op;

    data_t       result;
    data_t       imm_addi;
    data_t       imm_lu12i;

    // strobe is sampled on every edge, no back-pressure
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lat_valid <= 1'b0;
        end else begin
            lat_valid <= inst_valid;
        end
    end

    // instruction word and pc only move on a strobe
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            lat_inst <= inst;
            lat_pc   <= inst_pc;
        end
    end

    // register fields, LoongArch 3R / 2RI12 / 1RI20 layouts
    assign rd_idx = lat_inst[4:0];
    assign rj_idx = lat_inst[9:5];
    assign rk_idx = lat_inst[14:10];
    assign si12   = lat_inst[21:10];
    assign si20   = lat_inst[24:5];

    // each opcode has its own field width
    assign is_add_w   = (lat_inst[31:15] == `OP_ADD_W);
    assign is_addi_w  = (lat_inst[31:22] == `OP_ADDI_W);
    assign is_lu12i_w = (lat_inst[31:25] == `OP_LU12I_W);
    assign known_op   = is_add_w | is_addi_w | is_lu12i_w;

    // sign extended si12
    assign imm_addi  = {{(`XLEN-12){si12[11]}}, si12};
    // si20 placed in the upper bits, low 12 cleared
    assign imm_lu12i = {si20, 12'h000};

    // execute, operands already bypassed
    always_comb begin
        if (is_add_w) begin
            result = src1 + src2;
        end else if (is_addi_w) begin
            result = src1 + imm_addi;
        end else if (is_lu12i_w) begin
            result = imm_lu12i;
        end else begin
            // unknown word retires with no visible effect
            result = '0;
        end
    end

    // slot 0 captures this on the next edge
    assign out_valid = lat_valid;

    always_comb begin
        out_commit.pc     = lat_pc;
        out_commit.inst   = lat_inst;
        // writes to r0 are dropped here already
        out_commit.wen    = known_op && (rd_idx != '0);
        out_commit.wnum   = rd_idx;
        out_commit.result = result;
    end

endmodule

//--- hdl/operand_bypass.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module operand_bypass import core_pkg::*; (
    input  reg_idx_t                         rj_idx,
    input  reg_idx_t                         rk_idx,
    input  logic [`XLEN-1:0]                 rf_data1,
    input  logic [`XLEN-1:0]                 rf_data2,
    input  logic [`N_SLOTS-1:0]              slot_hit1,
    input  logic [`N_SLOTS-1:0]              slot_hit2,
    input  logic [`N_SLOTS-1:0][`XLEN-1:0]   slot_result,
    output logic [`XLEN-1:0]                 src1,
    output logic [`XLEN-1:0]                 src2
);

    // priority pick for one source
    // slot 0 holds the youngest result and wins over older slots
    function automatic logic [`XLEN-1:0] pick_operand(
        input reg_idx_t                       idx,
        input logic [`N_SLOTS-1:0]            hits,
        input logic [`N_SLOTS-1:0][`XLEN-1:0] results,
        input logic [`XLEN-1:0]               rf_data
    );
        logic [`XLEN-1:0] value;
        // register file is the fallback
        value = rf_data;
        // walk from oldest to youngest so the youngest overwrites
        for (int i = `N_SLOTS - 1; i >= 0; i--) begin
            if (hits[i]) begin
                value = results[i];
            end
        end
        // r0 is constant zero whatever the slots say
        if (idx == '0) begin
            value = '0;
        end
        return value;
    endfunction

    // rj operand
    always_comb begin
        src1 = pick_operand(rj_idx, slot_hit1, slot_result, rf_data1);
    end

    // rk operand
    always_comb begin
        src2 = pick_operand(rk_idx, slot_hit2, slot_result, rf_data2);
    end

endmodule

//--- hdl/pipe_slot.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module pipe_slot import core_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  commit_t  in_commit,
    input  reg_idx_t rd_idx1,
    input  reg_idx_t rd_idx2,
    output logic     out_valid,
    output commit_t  out_commit,
    output logic     hit1,
    output logic     hit2
);

    // valid always advances, nothing downstream stalls
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload follows the valid bit
    always_ff @(posedge clk) begin
        out_commit <= in_commit;
    end

    // destination match against the decode read indices
    // only a live, writing entry may forward
    assign hit1 = out_valid && out_commit.wen && (out_commit.wnum == rd_idx1);
    assign hit2 = out_valid && out_commit.wen && (out_commit.wnum == rd_idx2);

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module reg_file import core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  reg_idx_t              rd_idx1,
    input  reg_idx_t              rd_idx2,
    input  logic                  commit_valid,
    input  commit_t               commit,
    output logic [`XLEN-1:0]      rdata1,
    output logic [`XLEN-1:0]      rdata2,
    output logic                  debug_wb_valid,
    output logic [`XLEN-1:0]      debug_wb_pc,
    output logic [`XLEN-1:0]      debug_wb_inst,
    output logic [`DBG_WEN_W-1:0] debug_wb_rf_wen,
    output reg_idx_t              debug_wb_rf_wnum,
    output logic [`XLEN-1:0]      debug_wb_rf_wdata
);

    data_t regs [`REG_NUM];
    logic  do_write;

    // r0 never written, even if a slot claims it
    assign do_write = commit_valid && commit.wen && (commit.wnum != '0);

    // architectural state starts at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (do_write) begin
            regs[commit.wnum] <= commit.result;
        end
    end

    // combinational read ports, r0 tied low
    assign rdata1 = (rd_idx1 == '0) ? '0 : regs[rd_idx1];
    assign rdata2 = (rd_idx2 == '0) ? '0 : regs[rd_idx2];

    // commit strobe, one cycle per retired instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            debug_wb_valid <= 1'b0;
        end else begin
            debug_wb_valid <= commit_valid;
        end
    end

    // commit payload, registered with the write
    always_ff @(posedge clk) begin
        debug_wb_pc       <= commit.pc;
        debug_wb_inst     <= commit.inst;
        debug_wb_rf_wen   <= {`DBG_WEN_W{do_write}};
        debug_wb_rf_wnum  <= commit.wnum;
        debug_wb_rf_wdata <= commit.result;
    end

endmodule

//--- sim/core_tb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module core_tb import core_pkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_MARGIN = 200;

    // one expected retirement
    // due is the cycle count when it must show
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [3:0]  wen;
        logic [4:0]  wnum;
        logic [31:0] result;
        logic [31:0] due;
    } expect_t;

    logic                  clk;
    logic                  arst_n;
    logic                  inst_valid;
    logic [`XLEN-1:0]      inst;
    logic [`XLEN-1:0]      inst_pc;
    logic                  debug_wb_valid;
    logic [`XLEN-1:0]      debug_wb_pc;
    logic [`XLEN-1:0]      debug_wb_inst;
    logic [`DBG_WEN_W-1:0] debug_wb_rf_wen;
    reg_idx_t              debug_wb_rf_wnum;
    logic [`XLEN-1:0]      debug_wb_rf_wdata;

    // reference state
    logic [31:0] model_regs [32];
    expect_t     expect_q [$];
    expect_t     mon_exp;
    logic [31:0] next_pc;
    logic [15:0] lfsr_state;
    int          cycle_cnt;
    int          drive_cycles;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) i_tb_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    core_top i_core_top (
        .clk               (clk),
        .arst_n            (arst_n),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .inst_pc           (inst_pc),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_inst     (debug_wb_inst),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // right shifting 16 bit Galois LFSR
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    // one LFSR step per bit taken
    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] enc_add_w(input logic [4:0] rd, input logic [4:0] rj,
                                              input logic [4:0] rk);
        return {`OP_ADD_W, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_addi_w(input logic [4:0] rd, input logic [4:0] rj,
                                               input logic [11:0] si12);
        return {`OP_ADDI_W, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i_w(input logic [4:0] rd, input logic [19:0] si20);
        return {`OP_LU12I_W, si20, rd};
    endfunction

    // architectural effect of one word in issue order
    function automatic expect_t model_commit(input logic [31:0] word, input logic [31:0] pc);
        expect_t     e;
        logic [31:0] va;
        logic [31:0] vb;
        logic        known;
        va = (word[9:5] == 5'd0) ? 32'h0 : model_regs[word[9:5]];
        vb = (word[14:10] == 5'd0) ? 32'h0 : model_regs[word[14:10]];
        known = 1'b1;
        e.pc   = pc;
        e.inst = word;
        e.wnum = word[4:0];
        e.due  = '0;
        if (word[31:15] == `OP_ADD_W) begin
            e.result = va + vb;
        end else if (word[31:22] == `OP_ADDI_W) begin
            e.result = va + {{20{word[21]}}, word[21:10]};
        end else if (word[31:25] == `OP_LU12I_W) begin
            e.result = {word[24:5], 12'h000};
        end else begin
            // unknown word retires with a zero result
            known    = 1'b0;
            e.result = 32'h0;
        end
        e.wen = (known && word[4:0] != 5'd0) ? 4'hf : 4'h0;
        if (e.wen != 4'h0) begin
            model_regs[word[4:0]] = e.result;
        end
        return e;
    endfunction

    task automatic issue_inst(input logic [31:0] word);
        expect_t e;
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = word;
        inst_pc    = next_pc;
        e = model_commit(word, next_pc);
        // accepted at the next rising edge and retired N_SLOTS+1 edges later
        e.due = cycle_cnt + `N_SLOTS + 2;
        expect_q.push_back(e);
        next_pc = next_pc + 4;
        drive_cycles++;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            inst_valid = 1'b0;
            drive_cycles++;
        end
    endtask

    task automatic wait_drain();
        idle_cycles(1);
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic test_reset();
        // nothing may retire while the input is idle
        for (int i = 0; i < 20; i++) begin
            idle_cycles(1);
            check_value("debug_wb_valid", {31'h0, debug_wb_valid}, 32'h0);
        end
        issue_inst(enc_add_w(5'd1, 5'd0, 5'd0));
        wait_drain();
    endtask

    task automatic test_constants();
        issue_inst(enc_lu12i_w(5'd2, 20'h12345));
        idle_cycles(2);
        issue_inst(enc_addi_w(5'd2, 5'd2, 12'h678));
        idle_cycles(5);
        issue_inst(enc_lu12i_w(5'd3, 20'h80000));
        idle_cycles(1);
        issue_inst(enc_addi_w(5'd4, 5'd0, 12'hfff));
        idle_cycles(3);
        issue_inst(enc_addi_w(5'd3, 5'd3, 12'h7ff));
        wait_drain();
    endtask

    task automatic test_dependencies();
        // gap 0 hits slot 0
        // gap N_SLOTS and above reads the register file
        for (int g = 0; g <= `N_SLOTS + 1; g++) begin
            issue_inst(enc_addi_w(5'd7, 5'd7, 12'(g + 1)));
            idle_cycles(g);
            issue_inst(enc_add_w(5'd8, 5'd7, 5'd7));
            idle_cycles(g);
            issue_inst(enc_add_w(5'd7, 5'd8, 5'd7));
            idle_cycles(g);
            issue_inst(enc_addi_w(5'd8, 5'd8, 12'hffd));
            idle_cycles(g);
            issue_inst(enc_add_w(5'd9, 5'd7, 5'd8));
        end
        wait_drain();
    endtask

    task automatic test_no_write();
        issue_inst(enc_lu12i_w(5'd10, 20'h0abcd));
        issue_inst(enc_addi_w(5'd11, 5'd0, 12'h123));
        // r0 destinations retire without a write
        issue_inst(enc_add_w(5'd0, 5'd10, 5'd11));
        issue_inst(enc_addi_w(5'd0, 5'd10, 12'h7ff));
        issue_inst(enc_lu12i_w(5'd0, 20'hfffff));
        issue_inst(enc_add_w(5'd12, 5'd0, 5'd0));
        // unknown opcode aimed at r10
        issue_inst(32'hfff0_000a);
        issue_inst(enc_add_w(5'd13, 5'd10, 5'd11));
        idle_cycles(`N_SLOTS + 1);
        issue_inst(enc_add_w(5'd14, 5'd10, 5'd0));
        issue_inst(enc_add_w(5'd15, 5'd11, 5'd0));
        wait_drain();
    endtask

    task automatic test_random();
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rj;
        logic [31:0] rk;
        logic [31:0] imm;
        logic [31:0] gap;
        for (int n = 0; n < 200; n++) begin
            random_bits(2, kind);
            random_bits(5, rd);
            random_bits(5, rj);
            random_bits(5, rk);
            random_bits(20, imm);
            random_bits(3, gap);
            case (kind % 3)
                0: issue_inst(enc_add_w(rd[4:0], rj[4:0], rk[4:0]));
                1: issue_inst(enc_addi_w(rd[4:0], rj[4:0], imm[11:0]));
                default: issue_inst(enc_lu12i_w(rd[4:0], imm[19:0]));
            endcase
            idle_cycles(gap % (`N_SLOTS + 2));
        end
        wait_drain();
    endtask

    // cycle count and watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > RESET_CYCLES + drive_cycles + `N_SLOTS + TIMEOUT_MARGIN) begin
            abort_run("timeout, the core stopped retiring instructions");
        end
    end

    // retirement monitor sampling where outputs are stable
    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            if (debug_wb_valid === 1'b1) begin
                if (expect_q.size() == 0) begin
                    abort_run("a commit came out with no instruction outstanding");
                end else begin
                    mon_exp = expect_q.pop_front();
                    if (cycle_cnt != mon_exp.due) begin
                        abort_run($sformatf("commit of pc %h came at cycle %0d, not %0d",
                                            mon_exp.pc, cycle_cnt, mon_exp.due));
                    end
                    check_value("debug_wb_pc", debug_wb_pc, mon_exp.pc);
                    check_value("debug_wb_inst", debug_wb_inst, mon_exp.inst);
                    check_value("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen},
                                {28'h0, mon_exp.wen});
                    check_value("debug_wb_rf_wnum", {27'h0, debug_wb_rf_wnum},
                                {27'h0, mon_exp.wnum});
                    check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, mon_exp.result);
                end
            end else if (debug_wb_valid !== 1'b0) begin
                abort_run("debug_wb_valid is unknown after reset");
            end else if (expect_q.size() != 0 && expect_q[0].due <= cycle_cnt) begin
                abort_run($sformatf("commit of pc %h never came out", expect_q[0].pc));
            end
        end
    end

    initial begin
        inst_valid   = 1'b0;
        inst         = '0;
        inst_pc      = '0;
        next_pc      = 32'h1c00_0000;
        lfsr_state   = 16'd43299;
        cycle_cnt    = 0;
        drive_cycles = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        @(posedge arst_n);
        test_reset();
        test_constants();
        test_dependencies();
        test_no_write();
        test_random();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real HALF_PERIOD  = 2.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    // free running clock, 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    // reset held from time zero, released away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- src.f
+incdir+hdl
hdl/core_pkg.sv
hdl/inst_decode_exec.sv
hdl/operand_bypass.sv
hdl/pipe_slot.sv
hdl/reg_file.sv
hdl/core_top.sv
sim/tb_clock_gen.sv
sim/core_tb.sv
